/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= audio_tb
FILELIST  ?= files.f
PASS_MSG  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir

/* files.f */
hdl/audio_pkg.sv
hdl/audio_fetch_if.sv
hdl/ram_if.sv
hdl/sample_ram.sv
hdl/vram_arbiter.sv
hdl/audio_dac.sv
hdl/audio_mixer.sv
hdl/audio_top.sv
testbench/audio_assertions.sv
testbench/audio_tb.sv

/* hdl/audio_dac.sv */
// Pulse density DAC

`timescale 1ns/1ps

module audio_dac (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [audio_pkg::DAC_W-1:0] value_i,
    output logic                        pulse_o
);

    logic [audio_pkg::DAC_W-1:0] acc;
    logic [audio_pkg::DAC_W:0]   sum;   // carry in the top bit

    assign sum = {1'b0, acc} + {1'b0, value_i};

    // first order sigma-delta, value_i ones per 256 clocks
    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc     <= '0;
            pulse_o <= 1'b0;
        end else begin
            acc     <= sum[audio_pkg::DAC_W-1:0];
            pulse_o <= sum[audio_pkg::DAC_W];
        end
    end

endmodule

/* hdl/audio_fetch_if.sv */
// Audio fetch request interface

`timescale 1ns/1ps

interface audio_fetch_if;

    logic              req;     // held until ack
    audio_pkg::addr_t  addr;
    logic              ack;     // one cycle pulse
    audio_pkg::word_t  word;    // valid with ack

    modport client (output req, output addr, input ack, input word);

    modport server (input req, input addr, output ack, output word);

endinterface

/* hdl/audio_mixer.sv */
// Multi-channel sample playback mixer

`timescale 1ns/1ps

module audio_mixer #(
    parameter int NCHAN = 4
) (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                audio_enable_i,
    input  logic [NCHAN*audio_pkg::VOL_W-1:0]    audio_vol_l_i,
    input  logic [NCHAN*audio_pkg::VOL_W-1:0]    audio_vol_r_i,
    input  logic [NCHAN*audio_pkg::PERIOD_W-1:0] audio_period_i,
    input  logic [NCHAN*audio_pkg::ADDR_W-1:0]   audio_start_i,
    input  logic [NCHAN*audio_pkg::LEN_W-1:0]    audio_len_i,
    input  logic [NCHAN-1:0]                     audio_restart_i,
    output logic [NCHAN-1:0]                     audio_reload_o,
    audio_fetch_if.client                        fetch,
    output logic                                 pdm_l_o,
    output logic                                 pdm_r_o
);

    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;
    localparam int PW     = audio_pkg::PERIOD_W;
    localparam int LW     = audio_pkg::LEN_W;
    localparam int AW     = audio_pkg::ADDR_W;
    localparam int VW     = audio_pkg::VOL_W;

    logic [CHAN_W-1:0]       fetch_chan;
    logic [CHAN_W-1:0]       mix_chan;
    audio_pkg::fetch_phase_t fetch_phase;
    audio_pkg::mix_phase_t   mix_phase;

    logic [PW:0]       chan_period [NCHAN];     // top bit forces a sample
    logic [LW:0]       chan_len    [NCHAN];     // top bit forces a reload
    logic [LW:0]       chan_len_n  [NCHAN];
    audio_pkg::addr_t  chan_addr   [NCHAN];
    audio_pkg::word_t  chan_buff   [NCHAN];
    audio_pkg::sbyte_t chan_val    [NCHAN];     // sample currently playing
    logic [NCHAN-1:0]  chan_ok;                 // buffer holds a fresh word
    logic [NCHAN-1:0]  chan_2nd;                // next sample is the low byte

    audio_pkg::sbyte_t mix_val;
    audio_pkg::sbyte_t vol_l;
    audio_pkg::sbyte_t vol_r;
    audio_pkg::sword_t mult_l;
    audio_pkg::sword_t mult_r;
    logic signed [audio_pkg::ACC_W-1:0] mix_l_acc;
    logic signed [audio_pkg::ACC_W-1:0] mix_r_acc;
    logic [audio_pkg::DAC_W-1:0]        output_l;
    logic [audio_pkg::DAC_W-1:0]        output_r;

    function automatic logic [CHAN_W-1:0] next_chan(input logic [CHAN_W-1:0] c);
        return (c == CHAN_W'(NCHAN - 1)) ? '0 : c + 1'b1;
    endfunction

    // scale down, clamp to signed 8 bits, then offset to unsigned
    function automatic logic [7:0] to_dac(input logic signed [audio_pkg::ACC_W-1:0] acc);
        logic signed [audio_pkg::ACC_W-1:0] s;
        s = acc >>> audio_pkg::VOL_SHIFT;
        if (s < -128) return 8'h00;
        if (s > 127) return 8'hff;
        return s[7:0] ^ 8'h80;
    endfunction

    always_comb begin
        for (int i = 0; i < NCHAN; i++) begin
            chan_len_n[i] = chan_len[i] - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch.req      <= 1'b0;
            fetch_chan     <= '0;
            fetch_phase    <= audio_pkg::FETCH_REQ;
            audio_reload_o <= '0;
            chan_ok        <= '0;
            chan_2nd       <= '0;
            for (int i = 0; i < NCHAN; i++) begin
                chan_period[i] <= '0;
                chan_len[i]    <= '0;
                chan_addr[i]   <= '0;
                chan_buff[i]   <= '0;
                chan_val[i]    <= '0;
            end
        end else begin
            // round-robin refill where the channel updates below take precedence
            case (fetch_phase)
                audio_pkg::FETCH_REQ: begin
                    fetch.addr <= chan_addr[fetch_chan];
                    if (audio_enable_i && !chan_ok[fetch_chan]) begin
                        fetch.req   <= 1'b1;
                        fetch_phase <= audio_pkg::FETCH_WAIT;
                    end else begin
                        fetch_chan <= next_chan(fetch_chan);
                    end
                end
                audio_pkg::FETCH_WAIT: begin
                    if (fetch.ack) begin
                        fetch.req             <= 1'b0;
                        chan_buff[fetch_chan] <= fetch.word;
                        chan_ok[fetch_chan]   <= 1'b1;
                        fetch_chan            <= next_chan(fetch_chan);
                        fetch_phase           <= audio_pkg::FETCH_REQ;
                    end
                end
                default: fetch_phase <= audio_pkg::FETCH_REQ;
            endcase

            for (int i = 0; i < NCHAN; i++) begin
                audio_reload_o[i] <= 1'b0;
                chan_period[i]    <= chan_period[i] - 1'b1;
                if (!audio_enable_i || audio_restart_i[i]) begin
                    chan_period[i][PW] <= 1'b1;     // emit on the next clock
                    chan_len[i][LW]    <= 1'b1;     // and reload right after it
                    chan_ok[i]         <= 1'b0;
                    chan_2nd[i]        <= 1'b1;
                    if (!audio_enable_i) begin
                        chan_buff[i] <= '0;         // silence while stopped
                        chan_val[i]  <= '0;
                    end
                end else if (chan_period[i][PW] || chan_period[i] == '0) begin
                    chan_period[i] <= {1'b0, audio_period_i[i*PW +: PW]};
                    chan_2nd[i]    <= !chan_2nd[i];
                    chan_val[i]    <= chan_2nd[i] ? chan_buff[i][7:0] : chan_buff[i][15:8];
                    if (chan_2nd[i]) begin
                        chan_ok[i] <= 1'b0;         // word used up
                        if (chan_len[i][LW] || chan_len_n[i][LW]) begin
                            chan_addr[i]      <= audio_start_i[i*AW +: AW];
                            chan_len[i]       <= {1'b0, audio_len_i[i*LW +: LW]};
                            audio_reload_o[i] <= 1'b1;
                        end else begin
                            chan_addr[i] <= chan_addr[i] + 1'b1;
                            chan_len[i]  <= chan_len_n[i];
                        end
                    end
                end
            end
        end
    end

    // both operands signed since volumes are never negative
    assign mult_l = mix_val * vol_l;
    assign mult_r = mix_val * vol_r;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_chan  <= '0;
            mix_phase <= audio_pkg::MIX_MULT;
            mix_val   <= '0;
            vol_l     <= '0;
            vol_r     <= '0;
            mix_l_acc <= '0;
            mix_r_acc <= '0;
            output_l  <= '0;
            output_r  <= '0;
        end else begin
            case (mix_phase)
                audio_pkg::MIX_MULT: begin
                    if (mix_chan == '0) begin      // one full pass done
                        output_l  <= to_dac(mix_l_acc);
                        output_r  <= to_dac(mix_r_acc);
                        mix_l_acc <= '0;
                        mix_r_acc <= '0;
                    end
                    mix_val   <= chan_val[mix_chan];
                    vol_l     <= {1'b0, audio_vol_l_i[mix_chan*VW +: VW]};
                    vol_r     <= {1'b0, audio_vol_r_i[mix_chan*VW +: VW]};
                    mix_phase <= audio_pkg::MIX_ACCUM;
                end
                audio_pkg::MIX_ACCUM: begin
                    mix_l_acc <= mix_l_acc + audio_pkg::ACC_W'(mult_l);
                    mix_r_acc <= mix_r_acc + audio_pkg::ACC_W'(mult_r);
                    mix_chan  <= next_chan(mix_chan);
                    mix_phase <= audio_pkg::MIX_MULT;
                end
                default: mix_phase <= audio_pkg::MIX_MULT;
            endcase
        end
    end

    audio_dac dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (output_l),
        .pulse_o (pdm_l_o)
    );

    audio_dac dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (output_r),
        .pulse_o (pdm_r_o)
    );

endmodule

/* hdl/audio_pkg.sv */
// Audio subsystem shared definitions

package audio_pkg;

    localparam int ADDR_W    = 10;  // 1024 sample words
    localparam int VOL_W     = 7;   // 64 is unity gain
    localparam int PERIOD_W  = 15;
    localparam int LEN_W     = 15;
    localparam int DAC_W     = 8;
    localparam int ACC_W     = 18;  // room for 8 full-scale channels
    localparam int VOL_SHIFT = 6;

    // two samples per word, high byte played first
    typedef logic [15:0] word_t;

    // signed sample, or a volume zero-extended to 8 bits
    typedef logic signed [7:0] sbyte_t;

    typedef logic signed [15:0] sword_t;

    typedef logic [ADDR_W-1:0] addr_t;

    // fetch engine phases
    typedef enum logic {
        FETCH_REQ,      // pick a channel, raise req if its buffer is empty
        FETCH_WAIT      // hold req until ack
    } fetch_phase_t;

    // mix loop phases, two clocks per channel
    typedef enum logic {
        MIX_MULT,
        MIX_ACCUM
    } mix_phase_t;

endpackage

/* hdl/audio_top.sv */
// Audio subsystem top level

`timescale 1ns/1ps

module audio_top #(
    parameter int NCHAN = 4
) (
    input  logic                                 clk,
    input  logic                                 reset_i,
    input  logic                                 host_req_i,
    input  logic                                 host_we_i,
    input  audio_pkg::addr_t                     host_addr_i,
    input  audio_pkg::word_t                     host_wdata_i,
    output logic                                 host_ack_o,
    output audio_pkg::word_t                     host_rdata_o,
    input  logic                                 audio_enable_i,
    input  logic [NCHAN*audio_pkg::VOL_W-1:0]    audio_vol_l_i,
    input  logic [NCHAN*audio_pkg::VOL_W-1:0]    audio_vol_r_i,
    input  logic [NCHAN*audio_pkg::PERIOD_W-1:0] audio_period_i,
    input  logic [NCHAN*audio_pkg::ADDR_W-1:0]   audio_start_i,
    input  logic [NCHAN*audio_pkg::LEN_W-1:0]    audio_len_i,
    input  logic [NCHAN-1:0]                     audio_restart_i,
    output logic [NCHAN-1:0]                     audio_reload_o,
    output logic                                 pdm_l_o,
    output logic                                 pdm_r_o
);

    audio_fetch_if fetch_bus ();
    ram_if         ram_bus ();

    vram_arbiter arbiter (
        .clk          (clk),
        .reset_i      (reset_i),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .audio        (fetch_bus.server),
        .mem          (ram_bus.master)
    );

    sample_ram ram (
        .clk (clk),
        .mem (ram_bus.slave)
    );

    audio_mixer #(
        .NCHAN (NCHAN)
    ) mixer (
        .clk             (clk),
        .reset_i         (reset_i),
        .audio_enable_i  (audio_enable_i),
        .audio_vol_l_i   (audio_vol_l_i),
        .audio_vol_r_i   (audio_vol_r_i),
        .audio_period_i  (audio_period_i),
        .audio_start_i   (audio_start_i),
        .audio_len_i     (audio_len_i),
        .audio_restart_i (audio_restart_i),
        .audio_reload_o  (audio_reload_o),
        .fetch           (fetch_bus.client),
        .pdm_l_o         (pdm_l_o),
        .pdm_r_o         (pdm_r_o)
    );

endmodule

/* hdl/ram_if.sv */
// Sample memory port interface

`timescale 1ns/1ps

interface ram_if;

    logic              en;
    logic              we;
    audio_pkg::addr_t  addr;
    audio_pkg::word_t  wdata;
    audio_pkg::word_t  rdata;   // valid the cycle after en

    modport master (output en, output we, output addr, output wdata, input rdata);

    modport slave (input en, input we, input addr, input wdata, output rdata);

endinterface

/* hdl/sample_ram.sv */
// Sample memory

`timescale 1ns/1ps

module sample_ram (
    input  logic   clk,
    ram_if.slave   mem
);

    localparam int DEPTH = 1 << audio_pkg::ADDR_W;

    audio_pkg::word_t words [DEPTH];

    // single port, write has priority over read
    always_ff @(posedge clk) begin
        if (mem.en) begin
            if (mem.we) begin
                words[mem.addr] <= mem.wdata;
            end else begin
                mem.rdata <= words[mem.addr];   // registered read
            end
        end
    end

endmodule

/* hdl/vram_arbiter.sv */
// Host and audio memory arbiter

`timescale 1ns/1ps

module vram_arbiter (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              host_req_i,
    input  logic              host_we_i,
    input  audio_pkg::addr_t  host_addr_i,
    input  audio_pkg::word_t  host_wdata_i,
    output logic              host_ack_o,
    output audio_pkg::word_t  host_rdata_o,
    audio_fetch_if.server     audio,
    ram_if.master             mem
);

    typedef enum logic {
        ARB_IDLE,
        ARB_RESPOND
    } arb_state_t;

    arb_state_t state;
    logic       last_host;      // host got the previous grant
    logic       grant_any;
    logic       grant_host;

    // host wins unless audio waits too and host was served last
    assign grant_host = host_req_i && (!audio.req || !last_host);
    assign grant_any  = (state == ARB_IDLE) && (host_req_i || audio.req);

    assign mem.en    = grant_any;
    assign mem.we    = grant_any && grant_host && host_we_i;
    assign mem.addr  = grant_host ? host_addr_i : audio.addr;
    assign mem.wdata = host_wdata_i;

    // response cycle, last_host names the client being answered
    assign host_ack_o   = (state == ARB_RESPOND) && last_host;
    assign audio.ack    = (state == ARB_RESPOND) && !last_host;
    assign host_rdata_o = mem.rdata;
    assign audio.word   = mem.rdata;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state     <= ARB_IDLE;
            last_host <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (grant_any) begin
                        last_host <= grant_host;
                        state     <= ARB_RESPOND;
                    end
                end
                ARB_RESPOND: state <= ARB_IDLE;    // requester drops req after ack
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

/* testbench/audio_assertions.sv */
// Memory handshake checks

`timescale 1ns/1ps

module audio_assertions #(
    parameter int NCHAN = 1
) (
    input logic              clk,
    input logic              reset_i,
    input logic              host_req_i,
    input logic              host_ack_i,
    input logic              req_i,
    input logic              ack_i,
    input audio_pkg::addr_t  addr_i,
    input logic [NCHAN-1:0]  reload_i
);

    // no ack without a pending request
    ack_has_req: assert property (@(posedge clk) disable iff (reset_i)
        (ack_i |-> req_i) and (host_ack_i |-> host_req_i))
        else $error("ack without a pending request");

    req_held: assert property (@(posedge clk) disable iff (reset_i)
        req_i && !ack_i |=> req_i && $stable(addr_i))
        else $error("audio request dropped or changed before ack");

    host_req_held: assert property (@(posedge clk) disable iff (reset_i)
        host_req_i && !host_ack_i |=> host_req_i)
        else $error("host request dropped before ack");

    // a client left waiting is served by the very next access
    take_turns: assert property (@(posedge clk) disable iff (reset_i)
        (host_ack_i && req_i |-> ##2 ack_i) and (ack_i && host_req_i |-> ##2 host_ack_i))
        else $error("waiting client not served next");

    reload_pulse: assert property (@(posedge clk) disable iff (reset_i)
        (reload_i & $past(reload_i)) == '0)
        else $error("reload pulse longer than one cycle");

endmodule

bind vram_arbiter audio_assertions #(.NCHAN(1)) arbiter_checks (
    .clk        (clk),
    .reset_i    (reset_i),
    .host_req_i (host_req_i),
    .host_ack_i (host_ack_o),
    .req_i      (audio.req),
    .ack_i      (audio.ack),
    .addr_i     (audio.addr),
    .reload_i   (1'b0)
);

bind audio_mixer audio_assertions #(.NCHAN(NCHAN)) mixer_checks (
    .clk        (clk),
    .reset_i    (reset_i),
    .host_req_i (1'b0),
    .host_ack_i (1'b0),
    .req_i      (fetch.req),
    .ack_i      (fetch.ack),
    .addr_i     (fetch.addr),
    .reload_i   (audio_reload_o)
);

/* testbench/audio_tb.sv */
// Audio subsystem testbench

`timescale 1ns/1ps

module audio_tb;

    localparam int NCHAN      = 4;
    localparam int VW         = audio_pkg::VOL_W;
    localparam int PW         = audio_pkg::PERIOD_W;
    localparam int LW         = audio_pkg::LEN_W;
    localparam int AW         = audio_pkg::ADDR_W;
    localparam int CLK_PERIOD = 100;
    localparam int SETTLE     = 400;                  // clocks until a new mix is steady
    localparam int PAIR_CYC   = 8 * 64 + SETTLE + 256;
    localparam int RUN_CYC    = 400 + 64 * 64 + 6 * PAIR_CYC + 1200 + 300;
    localparam int TIMEOUT    = 2 * RUN_CYC + 10000;

    logic                  clk;
    logic                  reset_i;
    logic                  host_req;
    logic                  host_we;
    audio_pkg::addr_t      host_addr;
    audio_pkg::word_t      host_wdata;
    logic                  host_ack;
    audio_pkg::word_t      host_rdata;
    logic                  enable;
    logic [NCHAN*VW-1:0]   vol_l;
    logic [NCHAN*VW-1:0]   vol_r;
    logic [NCHAN*PW-1:0]   period;
    logic [NCHAN*AW-1:0]   start;
    logic [NCHAN*LW-1:0]   len;
    logic [NCHAN-1:0]      restart;
    logic [NCHAN-1:0]      reload;
    logic                  pdm_l;
    logic                  pdm_r;

    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;
    logic [31:0] lcg_state = 32'hc81f_c58e;

    audio_top #(.NCHAN(NCHAN)) uut (
        .clk             (clk),
        .reset_i         (reset_i),
        .host_req_i      (host_req),
        .host_we_i       (host_we),
        .host_addr_i     (host_addr),
        .host_wdata_i    (host_wdata),
        .host_ack_o      (host_ack),
        .host_rdata_o    (host_rdata),
        .audio_enable_i  (enable),
        .audio_vol_l_i   (vol_l),
        .audio_vol_r_i   (vol_r),
        .audio_period_i  (period),
        .audio_start_i   (start),
        .audio_len_i     (len),
        .audio_restart_i (restart),
        .audio_reload_o  (reload),
        .pdm_l_o         (pdm_l),
        .pdm_r_o         (pdm_r)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // shift the mix sum to 8 bits, saturate and offset by 128
    function automatic int level_of(input int sum);
        int s;
        s = sum >>> 6;
        if (s > 127) s = 127;
        if (s < -128) s = -128;
        return s + 128;
    endfunction

    task automatic check_word(input string name, input audio_pkg::word_t exp,
                              input audio_pkg::word_t act);
        checks++;
        if (exp !== act) begin
            $display("FAIL %s expected %04h actual %04h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            $display("FAIL %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err0);
        tests++;
        if (errors == err0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - err0);
    endtask

    // one host access that holds req until the cycle after ack
    task automatic host_access(input logic we, input audio_pkg::addr_t a,
                               input audio_pkg::word_t d, output audio_pkg::word_t q);
        int n;
        @(negedge clk);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = a;
        host_wdata = d;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!host_ack && n < 64);
        if (!host_ack) begin
            $display("host access to address %0h got no ack", a);
            errors++;
        end
        q = host_rdata;
        @(negedge clk);
        host_req = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic fill(input int base, input int n, input audio_pkg::word_t w);
        audio_pkg::word_t q;
        for (int i = 0; i < n; i++) host_access(1'b1, AW'(base + i), w, q);
    endtask

    task automatic set_channel(input int ch, input int st, input int ln, input int per,
                               input int vl, input int vr);
        start[ch*AW +: AW]  = AW'(st);
        len[ch*LW +: LW]    = LW'(ln);
        period[ch*PW +: PW] = PW'(per);
        vol_l[ch*VW +: VW]  = VW'(vl);
        vol_r[ch*VW +: VW]  = VW'(vr);
    endtask

    task automatic count_ones(output int ones_l, output int ones_r);
        ones_l = 0;
        ones_r = 0;
        repeat (256) begin
            @(negedge clk);
            ones_l += int'(pdm_l);
            ones_r += int'(pdm_r);
        end
    endtask

    task automatic wait_reload(input int ch, input int limit, output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!reload[ch] && n < limit);
        if (!reload[ch]) begin
            $display("no reload pulse on channel %0d within %0d clocks", ch, limit);
            errors++;
        end
    endtask

    // channels 0 and 1 play constant samples s0 and s1 while the rest are muted
    task automatic play_pair(input string name, input int s0, input int s1,
                             input int vl0, input int vr0, input int vl1, input int vr1);
        int ones_l;
        int ones_r;
        @(negedge clk);
        enable = 1'b0;
        fill(0, 4, {s0[7:0], s0[7:0]});
        fill(16, 4, {s1[7:0], s1[7:0]});
        set_channel(0, 0, 3, 19, vl0, vr0);
        set_channel(1, 16, 3, 19, vl1, vr1);
        set_channel(2, 0, 3, 19, 0, 0);
        set_channel(3, 16, 3, 19, 0, 0);
        enable = 1'b1;
        repeat (SETTLE) @(negedge clk);
        count_ones(ones_l, ones_r);
        check_count({name, " left"}, level_of(s0 * vl0 + s1 * vl1), ones_l);
        check_count({name, " right"}, level_of(s0 * vr0 + s1 * vr1), ones_r);
    endtask

    task automatic test_reset();
        int err0;
        int ones_l;
        int ones_r;
        err0 = errors;
        repeat (16) begin
            @(negedge clk);
            check_bit("reset host ack", 1'b0, host_ack);
            check_word("reset reload", '0, 16'(reload));
            check_bit("reset pdm left", 1'b0, pdm_l);
            check_bit("reset pdm right", 1'b0, pdm_r);
        end
        reset_i = 1'b0;
        @(negedge clk);
        check_bit("after reset host ack", 1'b0, host_ack);
        check_word("after reset reload", '0, 16'(reload));
        check_bit("after reset pdm left", 1'b0, pdm_l);
        check_bit("after reset pdm right", 1'b0, pdm_r);
        repeat (50) @(negedge clk);
        count_ones(ones_l, ones_r);
        check_count("disabled left", 128, ones_l);
        check_count("disabled right", 128, ones_r);
        report("reset and disable", err0);
    endtask

    task automatic test_host();
        int err0;
        audio_pkg::addr_t a [16];
        audio_pkg::word_t d [16];
        audio_pkg::word_t q;
        err0 = errors;
        for (int ch = 0; ch < NCHAN; ch++) set_channel(ch, ch * 8, 7, 16, 10, 10);
        fill(0, NCHAN * 8, 16'h0000);       // known samples for the playing channels
        enable = 1'b1;
        for (int i = 0; i < 16; i++) begin
            a[i] = AW'(512 + i * 16 + int'(lcg_next() & 32'hf));
            d[i] = 16'(lcg_next() >> 8);
            host_access(1'b1, a[i], d[i], q);
        end
        for (int i = 0; i < 16; i++) begin
            host_access(1'b0, a[i], '0, q);
            check_word("host readback", d[i], q);
        end
        report("host memory access", err0);
    endtask

    task automatic test_reload();
        int err0;
        int n;
        err0 = errors;
        @(negedge clk);
        enable = 1'b0;
        set_channel(0, 0, 3, 19, 0, 0);
        @(negedge clk);
        enable = 1'b1;
        wait_reload(0, 20, n);
        wait_reload(0, 640, n);
        wait_reload(0, 640, n);
        check_count("reload spacing", 2 * (3 + 1) * (19 + 1), n);
        report("loop reload timing", err0);
    endtask

    task automatic test_restart();
        int err0;
        logic seen;
        logic other;
        err0 = errors;
        seen  = 1'b0;
        other = 1'b0;
        @(negedge clk);
        enable = 1'b0;
        for (int ch = 0; ch < NCHAN; ch++) set_channel(ch, 0, 200, 30, 0, 0);
        @(negedge clk);
        enable = 1'b1;
        repeat (100) @(negedge clk);
        restart[2] = 1'b1;
        @(negedge clk);
        restart[2] = 1'b0;
        repeat (3) begin
            @(negedge clk);
            seen  = seen | reload[2];
            other = other | reload[0] | reload[1] | reload[3];
        end
        check_bit("restart reload on channel 2", 1'b1, seen);
        check_bit("reload on other channels", 1'b0, other);
        report("restart", err0);
    endtask

    initial begin
        int err0;
        reset_i    = 1'b1;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        enable     = 1'b0;
        vol_l      = '0;
        vol_r      = '0;
        period     = '0;
        start      = '0;
        len        = '0;
        restart    = '0;

        test_reset();
        test_host();

        err0 = errors;
        play_pair("level 64", 64, 0, 64, 32, 0, 0);
        play_pair("level -100", -100, 0, 64, 100, 0, 0);
        play_pair("level 37", 37, 0, 127, 5, 0, 0);
        report("single channel level", err0);

        err0 = errors;
        play_pair("clamp high", 100, 120, 127, 127, 127, 127);
        play_pair("clamp low", -100, -120, 127, 127, 127, 127);
        play_pair("mix sum", 20, -50, 64, 10, 32, 64);
        report("mixing and clamping", err0);

        test_reload();
        test_restart();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
